// ==== files.f ====
+incdir+hw
hw/usb_proto_pkg.sv
hw/monitor_pkg.sv
hw/packet_decoder.sv
hw/proxy_fsm.sv
hw/link_status.sv
hw/usb_monitor_top.sv
tests/tb_usb_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the USB monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_usb_monitor -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_usb_monitor)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Everything OK$"; then
    exit 0
fi
echo "Pass message not found"
exit 1

// ==== tests/tb_usb_monitor.sv ====
// USB proxy monitor testbench
// Random and token packets on both sides, a cycle model of every output
// and a compare process that checks the DUT on each falling edge

`timescale 1ns/1ps
`include "usb_monitor_cfg.svh"

module tb_usb_monitor;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_LEN    = 12;
    localparam int TOTAL_PKTS = 100;
    localparam int TIMEOUT_NS = TOTAL_PKTS * (MAX_LEN + 4) * CLK_PERIOD * 2;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_H2D  = 2'd1;
    localparam logic [1:0] S_D2H  = 2'd2;
    localparam logic [3:0] PID_OUT   = 4'b0001;
    localparam logic [3:0] PID_IN    = 4'b1001;
    localparam logic [3:0] PID_SETUP = 4'b1101;
    localparam logic [3:0] PID_SOF   = 4'b0101;

    logic clk = 1'b0;
    logic rst_n;
    logic [7:0] host_rx_data, device_rx_data, host_tx_data, device_tx_data;
    logic host_rx_valid, host_rx_sop, host_rx_eop, host_rx_crc_valid;
    logic device_rx_valid, device_rx_sop, device_rx_eop, device_rx_crc_valid;
    logic [3:0] host_rx_pid, device_rx_pid, host_tx_pid, device_tx_pid;
    logic host_tx_valid, host_tx_sop, host_tx_eop;
    logic device_tx_valid, device_tx_sop, device_tx_eop;
    logic [7:0] buffer_data, buffer_flags, event_type, status_register;
    logic buffer_valid, buffer_ready, event_valid, proxy_enable;
    logic [`USB_TS_WIDTH-1:0] buffer_timestamp;
    logic [`USB_TS_WIDTH-1:0] timestamp = 64'h0000_0100_0000_0000;
    logic [1:0] device_line_state;
    logic [`USB_ERR_WIDTH-1:0] error_count;
    logic [`USB_CNT_WIDTH-1:0] host_packets, device_packets;
    logic [10:0] frame_number;
    logic [6:0] token_addr;
    logic [3:0] token_endp;

    integer seed = 26902;
    int n_checks = 0;
    int n_errors = 0;
    logic [7:0] host_bytes [];
    logic [7:0] dev_bytes [];

    // Expected outputs and model state
    logic [7:0] exp_dtx_data = '0, exp_htx_data = '0;
    logic exp_dtx_valid = 1'b0, exp_dtx_sop = 1'b0, exp_dtx_eop = 1'b0;
    logic exp_htx_valid = 1'b0, exp_htx_sop = 1'b0, exp_htx_eop = 1'b0;
    logic [3:0] exp_dtx_pid = '0, exp_htx_pid = '0;
    logic exp_buf_valid = 1'b0;
    logic [7:0] exp_buf_data = '0, exp_buf_flags = '0, exp_status = '0;
    logic [63:0] exp_buf_ts = '0, m_ts = '0;
    logic [31:0] exp_host_pk = '0, exp_dev_pk = '0;
    logic [10:0] exp_frame = '0;
    logic [6:0] exp_addr = '0;
    logic [3:0] exp_endp = '0, m_pid = '0;
    logic [15:0] exp_err_cnt = '0;
    logic [1:0] m_state = S_IDLE, m_speed = '0;
    logic [7:0] m_byte1 = '0;
    int m_hcnt = 0;
    logic m_crc_pend = 1'b0, m_err = 1'b0, m_conn = 1'b0, m_en = 1'b0;
    logic m_h_go = 1'b0, m_d_go = 1'b0, m_h2d = 1'b0, m_d2h = 1'b0;

    usb_monitor_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) timestamp <= timestamp + 64'd1;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Combinational forwarding for the current cycle
    function automatic void predict_forwarding();
        m_h_go = (m_state == S_IDLE) && proxy_enable && host_rx_valid && host_rx_sop;
        m_d_go = (m_state == S_IDLE) && proxy_enable && device_rx_valid && device_rx_sop
                 && !m_h_go;                                  // Host wins a tie
        m_h2d = (m_state == S_H2D) || m_h_go;
        m_d2h = (m_state == S_D2H) || m_d_go;
        exp_dtx_valid = m_h2d && host_rx_valid;
        exp_dtx_sop   = exp_dtx_valid && host_rx_sop;
        exp_dtx_eop   = exp_dtx_valid && host_rx_eop;
        exp_dtx_data  = m_h2d ? host_rx_data : 8'h00;
        exp_dtx_pid   = m_h2d ? host_rx_pid : 4'h0;
        exp_htx_valid = m_d2h && device_rx_valid;
        exp_htx_sop   = exp_htx_valid && device_rx_sop;
        exp_htx_eop   = exp_htx_valid && device_rx_eop;
        exp_htx_data  = m_d2h ? device_rx_data : 8'h00;
        exp_htx_pid   = m_d2h ? device_rx_pid : 4'h0;
    endfunction

    // Registered outputs as they will be after the next rising edge
    function automatic void advance_model();
        logic [3:0] pid;
        logic [15:0] word;
        int idx;
        if (!rst_n) begin
            {exp_buf_valid, exp_buf_data, exp_buf_flags, exp_buf_ts} = '0;
            {exp_host_pk, exp_dev_pk, exp_frame, exp_addr, exp_endp} = '0;
            {exp_err_cnt, exp_status, m_state, m_speed, m_hcnt} = '0;
            {m_crc_pend, m_err, m_conn, m_en} = '0;
            return;
        end
        exp_buf_valid = ((m_h2d && host_rx_valid) || (m_d2h && device_rx_valid)) && buffer_ready;
        if (exp_buf_valid) begin
            pid = m_h_go ? host_rx_pid : (m_d_go ? device_rx_pid : m_pid);
            exp_buf_data  = m_h2d ? host_rx_data : device_rx_data;
            exp_buf_flags = {3'b000, pid, m_d2h};
            exp_buf_ts    = (m_h_go || m_d_go) ? timestamp : m_ts;
        end
        if (m_h_go || m_d_go) begin
            m_pid = m_h_go ? host_rx_pid : device_rx_pid;
            m_ts  = timestamp;
        end
        if (m_h_go) exp_host_pk = exp_host_pk + 32'd1;
        if (m_d_go) exp_dev_pk = exp_dev_pk + 32'd1;
        case (m_state)
            S_IDLE: begin
                if (m_h_go && !host_rx_eop) m_state = S_H2D;
                else if (m_d_go && !device_rx_eop) m_state = S_D2H;
            end
            S_H2D: if (host_rx_valid && host_rx_eop) m_state = S_IDLE;
            S_D2H: if (device_rx_valid && device_rx_eop) m_state = S_IDLE;
            default: m_state = S_IDLE;
        endcase
        // Token decode, 3 host bytes with good CRC
        if (host_rx_valid) begin
            idx = host_rx_sop ? 0 : m_hcnt;
            if (idx == 1) m_byte1 = host_rx_data;
            if (host_rx_eop && host_rx_crc_valid && idx == 2) begin
                word = {host_rx_data, m_byte1};
                if (host_rx_pid == PID_SOF) begin
                    exp_frame = word[10:0];
                end else if (host_rx_pid == PID_OUT || host_rx_pid == PID_IN ||
                             host_rx_pid == PID_SETUP) begin
                    exp_addr = word[6:0];
                    exp_endp = word[10:7];
                end
            end
            m_hcnt = idx + 1;
        end
        if (m_crc_pend) begin
            exp_err_cnt = exp_err_cnt + 16'd1;
            m_err = 1'b1;
        end
        m_crc_pend = (host_rx_valid && host_rx_eop && !host_rx_crc_valid) ||
                     (device_rx_valid && device_rx_eop && !device_rx_crc_valid);
        m_conn = (device_line_state != 2'b00);
        m_en = proxy_enable;
        if (event_valid && event_type == 8'h01) m_speed = 2'd1;
        if (event_valid && event_type == 8'h02) m_speed = 2'd2;
        if (event_valid && event_type == 8'h03) m_speed = 2'd0;
        exp_status = {m_speed, 3'b000, m_en, m_err, m_conn};
    endfunction

    task automatic compare_value(input string what, input logic [63:0] actual,
                                 input logic [63:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("Error at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    always @(negedge clk) begin
        predict_forwarding();
        compare_value("device_tx_data", 64'(device_tx_data), 64'(exp_dtx_data));
        compare_value("device_tx_valid", 64'(device_tx_valid), 64'(exp_dtx_valid));
        compare_value("device_tx_sop", 64'(device_tx_sop), 64'(exp_dtx_sop));
        compare_value("device_tx_eop", 64'(device_tx_eop), 64'(exp_dtx_eop));
        compare_value("device_tx_pid", 64'(device_tx_pid), 64'(exp_dtx_pid));
        compare_value("host_tx_data", 64'(host_tx_data), 64'(exp_htx_data));
        compare_value("host_tx_valid", 64'(host_tx_valid), 64'(exp_htx_valid));
        compare_value("host_tx_sop", 64'(host_tx_sop), 64'(exp_htx_sop));
        compare_value("host_tx_eop", 64'(host_tx_eop), 64'(exp_htx_eop));
        compare_value("host_tx_pid", 64'(host_tx_pid), 64'(exp_htx_pid));
        compare_value("buffer_valid", 64'(buffer_valid), 64'(exp_buf_valid));
        if (exp_buf_valid) begin   // Contents only matter with a record
            compare_value("buffer_data", 64'(buffer_data), 64'(exp_buf_data));
            compare_value("buffer_flags", 64'(buffer_flags), 64'(exp_buf_flags));
            compare_value("buffer_timestamp", buffer_timestamp, exp_buf_ts);
        end
        compare_value("host_packets", 64'(host_packets), 64'(exp_host_pk));
        compare_value("device_packets", 64'(device_packets), 64'(exp_dev_pk));
        compare_value("frame_number", 64'(frame_number), 64'(exp_frame));
        compare_value("token_addr", 64'(token_addr), 64'(exp_addr));
        compare_value("token_endp", 64'(token_endp), 64'(exp_endp));
        compare_value("error_count", 64'(error_count), 64'(exp_err_cnt));
        compare_value("status_register", 64'(status_register), 64'(exp_status));
        advance_model();
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic logic [3:0] rand_pid();
        case (rand_below(12))
            0: return 4'b0001;  1: return 4'b1001;  2: return 4'b1101;  3: return 4'b0101;
            4: return 4'b0011;  5: return 4'b1011;  6: return 4'b0111;  7: return 4'b1111;
            8: return 4'b0010;  9: return 4'b1010; 10: return 4'b1110; default: return 4'b0110;
        endcase
    endfunction

    task automatic fill_bytes();
        for (int i = 0; i < MAX_LEN; i++) begin
            host_bytes[i] = 8'(rand_below(256));
            dev_bytes[i]  = 8'(rand_below(256));
        end
    endtask

    // Both packets start in the same cycle, length 0 keeps a side silent
    task automatic send_pair(input int hlen, input int dlen, input logic [3:0] hpid,
                             input logic [3:0] dpid, input logic hcrc, input logic dcrc);
        int n;
        n = (hlen > dlen) ? hlen : dlen;
        host_bytes[0] = {~hpid, hpid};
        dev_bytes[0]  = {~dpid, dpid};
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            host_rx_valid <= (i < hlen);
            host_rx_sop <= (i == 0) && (hlen > 0);
            host_rx_eop <= (i == hlen - 1);
            host_rx_data <= (i < hlen) ? host_bytes[i] : 8'h00;
            host_rx_pid <= hpid;
            host_rx_crc_valid <= hcrc;
            device_rx_valid <= (i < dlen);
            device_rx_sop <= (i == 0) && (dlen > 0);
            device_rx_eop <= (i == dlen - 1);
            device_rx_data <= (i < dlen) ? dev_bytes[i] : 8'h00;
            device_rx_pid <= dpid;
            device_rx_crc_valid <= dcrc;
            buffer_ready <= (rand_below(4) != 0);
        end
        @(posedge clk);
        {host_rx_valid, host_rx_sop, host_rx_eop, host_rx_data, host_rx_pid} <= '0;
        {device_rx_valid, device_rx_sop, device_rx_eop, device_rx_data, device_rx_pid} <= '0;
    endtask

    task automatic send_token(input logic [3:0] pid, input logic [15:0] word,
                              input logic crc_ok, input int len);
        fill_bytes();
        host_bytes[1] = word[7:0];
        host_bytes[2] = word[15:8];
        send_pair(len, 0, pid, 4'h0, crc_ok, 1'b1);
        @(negedge clk);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [15:0] word;
        logic [10:0] old_frame;
        logic [6:0] old_addr;
        host_bytes = new[MAX_LEN];
        dev_bytes = new[MAX_LEN];
        rst_n = 1'b0;
        {host_rx_data, host_rx_valid, host_rx_sop, host_rx_eop, host_rx_pid} = '0;
        host_rx_crc_valid = 1'b1;
        {device_rx_data, device_rx_valid, device_rx_sop, device_rx_eop, device_rx_pid} = '0;
        device_rx_crc_valid = 1'b1;
        {buffer_ready, event_valid, event_type, proxy_enable, device_line_state} = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        proxy_enable <= 1'b1;
        device_line_state <= 2'b01;
        repeat (2) @(posedge clk);

        for (int k = 0; k < 20; k++) begin   // Host to device
            fill_bytes();
            send_pair(1 + rand_below(MAX_LEN), 0, rand_pid(), 4'h0, rand_below(5) != 0, 1'b1);
        end
        for (int k = 0; k < 20; k++) begin   // Device to host
            fill_bytes();
            send_pair(0, 1 + rand_below(MAX_LEN), 4'h0, rand_pid(), 1'b1, rand_below(5) != 0);
        end
        for (int k = 0; k < 30; k++) begin   // Both sides, last 10 with proxying off
            if (k == 20) proxy_enable <= 1'b0;
            fill_bytes();
            send_pair(rand_below(MAX_LEN + 1), rand_below(MAX_LEN + 1), rand_pid(), rand_pid(),
                      rand_below(5) != 0, rand_below(5) != 0);
        end
        proxy_enable <= 1'b1;

        // Token decode through both views of the word
        word = 16'(rand_below(65536));
        send_token(PID_SOF, word, 1'b1, 3);
        compare_value("frame_number after SOF", 64'(frame_number), 64'(word[10:0]));
        word = 16'(rand_below(65536));
        send_token(PID_OUT, word, 1'b1, 3);
        compare_value("token_addr after OUT", 64'(token_addr), 64'(word[6:0]));
        compare_value("token_endp after OUT", 64'(token_endp), 64'(word[10:7]));
        word = 16'(rand_below(65536));
        send_token(PID_SETUP, word, 1'b1, 3);
        compare_value("token_addr after SETUP", 64'(token_addr), 64'(word[6:0]));
        send_token(PID_IN, 16'(rand_below(65536)), 1'b1, 3);
        old_frame = frame_number;
        old_addr = token_addr;
        send_token(PID_SOF, ~{5'h00, old_frame}, 1'b0, 3);
        send_token(PID_SOF, ~{5'h00, old_frame}, 1'b1, 4);
        compare_value("frame_number kept", 64'(frame_number), 64'(old_frame));
        send_token(PID_OUT, ~{9'h000, old_addr}, 1'b0, 3);
        compare_value("token_addr kept", 64'(token_addr), 64'(old_addr));

        for (int k = 0; k < 20; k++) begin   // Line state and PHY events
            @(posedge clk);
            device_line_state <= 2'(rand_below(4));
            event_valid <= 1'b1;
            event_type <= (k == 7) ? 8'hff : 8'(rand_below(6));
            @(posedge clk);
            event_valid <= 1'b0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== hw/usb_monitor_top.sv ====
// Transparent USB proxy monitor
// Forwards decoded packets between host and device, logs every forwarded
// byte, decodes host tokens and tracks link status

`timescale 1ns/1ps
`include "usb_monitor_cfg.svh"

module usb_monitor_top (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic [7:0]                host_rx_data,
    input  logic                      host_rx_valid,
    input  logic                      host_rx_sop,
    input  logic                      host_rx_eop,
    input  logic [3:0]                host_rx_pid,
    input  logic                      host_rx_crc_valid,
    output logic [7:0]                host_tx_data,
    output logic                      host_tx_valid,
    output logic                      host_tx_sop,
    output logic                      host_tx_eop,
    output logic [3:0]                host_tx_pid,

    input  logic [7:0]                device_rx_data,
    input  logic                      device_rx_valid,
    input  logic                      device_rx_sop,
    input  logic                      device_rx_eop,
    input  logic [3:0]                device_rx_pid,
    input  logic                      device_rx_crc_valid,
    output logic [7:0]                device_tx_data,
    output logic                      device_tx_valid,
    output logic                      device_tx_sop,
    output logic                      device_tx_eop,
    output logic [3:0]                device_tx_pid,

    output logic [7:0]                buffer_data,
    output logic                      buffer_valid,
    output logic [`USB_TS_WIDTH-1:0]  buffer_timestamp,
    output logic [7:0]                buffer_flags,
    input  logic                      buffer_ready,

    input  logic [`USB_TS_WIDTH-1:0]  timestamp,
    input  logic [1:0]                device_line_state,
    input  logic                      event_valid,
    input  logic [7:0]                event_type,
    input  logic                      proxy_enable,

    output logic [7:0]                status_register,
    output logic [`USB_ERR_WIDTH-1:0] error_count,
    output logic [`USB_CNT_WIDTH-1:0] host_packets,
    output logic [`USB_CNT_WIDTH-1:0] device_packets,
    output logic [10:0]               frame_number,
    output logic [6:0]                token_addr,
    output logic [3:0]                token_endp
);

    logic crc_error;    // Decoder to status, one pulse per bad packet

    packet_decoder u_decode (
        .clk, .rst_n,
        .host_rx_data, .host_rx_valid, .host_rx_sop, .host_rx_eop,
        .host_rx_pid, .host_rx_crc_valid,
        .device_rx_valid, .device_rx_eop, .device_rx_crc_valid,
        .crc_error, .frame_number, .token_addr, .token_endp
    );

    proxy_fsm u_execute (
        .clk, .rst_n,
        .host_rx_data, .host_rx_valid, .host_rx_sop, .host_rx_eop, .host_rx_pid,
        .host_tx_data, .host_tx_valid, .host_tx_sop, .host_tx_eop, .host_tx_pid,
        .device_rx_data, .device_rx_valid, .device_rx_sop, .device_rx_eop,
        .device_rx_pid,
        .device_tx_data, .device_tx_valid, .device_tx_sop, .device_tx_eop,
        .device_tx_pid,
        .proxy_enable, .timestamp,
        .buffer_data, .buffer_valid, .buffer_timestamp, .buffer_flags, .buffer_ready,
        .host_packets, .device_packets
    );

    link_status u_result (
        .clk, .rst_n,
        .crc_error, .device_line_state, .event_valid, .event_type, .proxy_enable,
        .status_register, .error_count
    );

endmodule

// ==== hw/link_status.sv ====
// Link status tracking
// Connection, device speed, CRC error count and the status register

`timescale 1ns/1ps
`include "usb_monitor_cfg.svh"

module link_status import monitor_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      crc_error,
    input  logic [1:0]                device_line_state,
    input  logic                      event_valid,
    input  logic [7:0]                event_type,
    input  logic                      proxy_enable,
    output logic [7:0]                status_register,
    output logic [`USB_ERR_WIDTH-1:0] error_count
);

    logic       connected_q;
    logic       error_q;    // Sticky until reset
    logic       enable_q;
    usb_speed_e speed_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            connected_q <= 1'b0;
            enable_q    <= 1'b0;
        end else begin
            connected_q <= (device_line_state != 2'b00); // SE0 means detached
            enable_q    <= proxy_enable;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            speed_q <= LOW;
        end else if (event_valid) begin
            case (event_type)
                EVT_FULL_SPEED: speed_q <= FULL;
                EVT_HIGH_SPEED: speed_q <= HIGH;
                EVT_LOW_SPEED:  speed_q <= LOW;
                default: ;      // Unknown events keep the last speed
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_q     <= 1'b0;
            error_count <= '0;
        end else if (crc_error) begin
            error_q <= 1'b1;
            if (error_count != '1) begin
                error_count <= error_count + 1'b1; // Saturates
            end
        end
    end

    ////////////////////////////////////////
    // Status register
    ////////////////////////////////////////

    always_comb begin
        status_register = '0;
        status_register[STAT_CONNECTED]     = connected_q;
        status_register[STAT_ERROR]         = error_q;
        status_register[STAT_ENABLE]        = enable_q;
        status_register[STAT_SPEED_LSB +: 2] = speed_q;
    end

    a_err_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        error_count >= $past(error_count));

endmodule

// ==== hw/proxy_fsm.sv ====
// Proxy forwarding FSM
// Forwards one packet at a time between host and device with no added latency,
// counts packets per side and emits one capture record per forwarded byte

`timescale 1ns/1ps
`include "usb_monitor_cfg.svh"

module proxy_fsm import monitor_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic [7:0]                host_rx_data,
    input  logic                      host_rx_valid,
    input  logic                      host_rx_sop,
    input  logic                      host_rx_eop,
    input  logic [3:0]                host_rx_pid,
    output logic [7:0]                host_tx_data,
    output logic                      host_tx_valid,
    output logic                      host_tx_sop,
    output logic                      host_tx_eop,
    output logic [3:0]                host_tx_pid,

    input  logic [7:0]                device_rx_data,
    input  logic                      device_rx_valid,
    input  logic                      device_rx_sop,
    input  logic                      device_rx_eop,
    input  logic [3:0]                device_rx_pid,
    output logic [7:0]                device_tx_data,
    output logic                      device_tx_valid,
    output logic                      device_tx_sop,
    output logic                      device_tx_eop,
    output logic [3:0]                device_tx_pid,

    input  logic                      proxy_enable,
    input  logic [`USB_TS_WIDTH-1:0]  timestamp,

    output logic [7:0]                buffer_data,
    output logic                      buffer_valid,
    output logic [`USB_TS_WIDTH-1:0]  buffer_timestamp,
    output logic [7:0]                buffer_flags,
    input  logic                      buffer_ready,

    output logic [`USB_CNT_WIDTH-1:0] host_packets,
    output logic [`USB_CNT_WIDTH-1:0] device_packets
);

    proxy_state_e              state;
    logic [3:0]                pkt_pid_q;
    logic [`USB_TS_WIDTH-1:0]  pkt_ts_q;
    logic                      host_start;
    logic                      dev_start;
    logic                      fwd_h2d;
    logic                      fwd_d2h;
    logic                      log_fire;
    logic [3:0]                log_pid;
    logic [`USB_TS_WIDTH-1:0]  log_ts;
    logic [7:0]                log_flags;

    // Host wins a tie in idle
    assign host_start = (state == IDLE) && proxy_enable && host_rx_valid && host_rx_sop;
    assign dev_start  = (state == IDLE) && proxy_enable && device_rx_valid && device_rx_sop &&
                        !host_start;

    assign fwd_h2d = (state == HOST_TO_DEVICE) || host_start;
    assign fwd_d2h = (state == DEVICE_TO_HOST) || dev_start;

    ////////////////////////////////////////
    // Forwarding paths
    ////////////////////////////////////////

    assign device_tx_data  = fwd_h2d ? host_rx_data : 8'h00;
    assign device_tx_valid = fwd_h2d && host_rx_valid;
    assign device_tx_sop   = fwd_h2d && host_rx_valid && host_rx_sop;
    assign device_tx_eop   = fwd_h2d && host_rx_valid && host_rx_eop;
    assign device_tx_pid   = fwd_h2d ? host_rx_pid : 4'h0;

    assign host_tx_data    = fwd_d2h ? device_rx_data : 8'h00;
    assign host_tx_valid   = fwd_d2h && device_rx_valid;
    assign host_tx_sop     = fwd_d2h && device_rx_valid && device_rx_sop;
    assign host_tx_eop     = fwd_d2h && device_rx_valid && device_rx_eop;
    assign host_tx_pid     = fwd_d2h ? device_rx_pid : 4'h0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    // Single byte packets stay in idle
                    if (host_start && !host_rx_eop) begin
                        state <= HOST_TO_DEVICE;
                    end else if (dev_start && !device_rx_eop) begin
                        state <= DEVICE_TO_HOST;
                    end
                end
                HOST_TO_DEVICE: begin
                    if (host_rx_valid && host_rx_eop) begin
                        state <= IDLE;
                    end
                end
                DEVICE_TO_HOST: begin
                    if (device_rx_valid && device_rx_eop) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Packet context latched at the sop byte
    always_ff @(posedge clk) begin
        if (host_start) begin
            pkt_pid_q <= host_rx_pid;
            pkt_ts_q  <= timestamp;
        end else if (dev_start) begin
            pkt_pid_q <= device_rx_pid;
            pkt_ts_q  <= timestamp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            host_packets   <= '0;
            device_packets <= '0;
        end else if (host_start) begin
            host_packets <= host_packets + 1'b1;
        end else if (dev_start) begin
            device_packets <= device_packets + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Capture log
    ////////////////////////////////////////

    // Dropped when the buffer is not ready and never stalls forwarding
    assign log_fire = ((fwd_h2d && host_rx_valid) || (fwd_d2h && device_rx_valid)) &&
                      buffer_ready;

    // The sop byte has no latched context yet
    assign log_pid = host_start ? host_rx_pid :
                     dev_start  ? device_rx_pid : pkt_pid_q;
    assign log_ts  = (state == IDLE) ? timestamp : pkt_ts_q;

    always_comb begin
        log_flags = '0;
        log_flags[FLAG_DIR] = fwd_h2d ? DIR_HOST_TO_DEVICE : DIR_DEVICE_TO_HOST;
        log_flags[FLAG_PID_LSB +: 4] = log_pid;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buffer_valid     <= 1'b0;
            buffer_data      <= '0;
            buffer_flags     <= '0;
            buffer_timestamp <= '0;
        end else begin
            buffer_valid <= log_fire;
            if (log_fire) begin
                buffer_data      <= fwd_h2d ? host_rx_data : device_rx_data;
                buffer_flags     <= log_flags;
                buffer_timestamp <= log_ts;
            end
        end
    end

    // Only one direction is ever on the wire
    a_one_direction: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_tx_valid && device_tx_valid));

    // Back to back records inside one packet keep its flags and timestamp
    a_log_context_held: assert property (@(posedge clk) disable iff (!rst_n)
        (buffer_valid && $past(buffer_valid) && ($past(state) != IDLE)) |->
        ((buffer_flags == $past(buffer_flags)) &&
         (buffer_timestamp == $past(buffer_timestamp))));

endmodule

// ==== hw/packet_decoder.sv ====
// Host token decoder and CRC checker
// Picks the frame number out of SOF packets and address/endpoint out of
// OUT, IN and SETUP tokens, and flags bad CRC on either side

`timescale 1ns/1ps
`include "usb_monitor_cfg.svh"

module packet_decoder import usb_proto_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic [7:0]  host_rx_data,
    input  logic        host_rx_valid,
    input  logic        host_rx_sop,
    input  logic        host_rx_eop,
    input  logic [3:0]  host_rx_pid,
    input  logic        host_rx_crc_valid,

    input  logic        device_rx_valid,
    input  logic        device_rx_eop,
    input  logic        device_rx_crc_valid,

    output logic        crc_error,
    output logic [10:0] frame_number,
    output logic [6:0]  token_addr,
    output logic [3:0]  token_endp
);

    logic [`USB_BCNT_WIDTH-1:0] bcnt_q;   // Host bytes seen so far
    logic [`USB_BCNT_WIDTH-1:0] byte_idx; // Position of the current byte
    logic [7:0]                 byte1_q;
    token_word_u                tok;
    logic                       token_done;

    assign byte_idx = host_rx_sop ? '0 : bcnt_q;

    // Byte 2 is still on the bus in the eop cycle
    assign tok = {host_rx_data, byte1_q};

    assign token_done = host_rx_valid && host_rx_eop && host_rx_crc_valid &&
                        (byte_idx == `USB_TOKEN_LEN - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bcnt_q <= '0;
        end else if (host_rx_valid) begin
            if (byte_idx != '1) begin
                bcnt_q <= byte_idx + 1'b1;
            end else begin
                bcnt_q <= byte_idx; // Long packet, stop counting
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_rx_valid && byte_idx == 1) begin
            byte1_q <= host_rx_data;
        end
    end

    ////////////////////////////////////////
    // Field update at end of packet
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_number <= '0;
            token_addr   <= '0;
            token_endp   <= '0;
        end else if (token_done) begin
            case (usb_pid_e'(host_rx_pid))
                PID_SOF: begin
                    frame_number <= tok.sof.frame;
                end
                PID_OUT, PID_IN, PID_SETUP: begin
                    token_addr <= tok.token.addr;
                    token_endp <= tok.token.endp;
                end
                default: ;  // Handshake and data packets carry no token
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_error <= 1'b0;
        end else begin
            crc_error <= (host_rx_valid && host_rx_eop && !host_rx_crc_valid) ||
                         (device_rx_valid && device_rx_eop && !device_rx_crc_valid);
        end
    end

endmodule

// ==== hw/monitor_pkg.sv ====
// Monitor side definitions
// Proxy state, link speed, PHY event codes, log flag and status bit positions

package monitor_pkg;

    typedef enum logic [1:0] {
        IDLE           = 2'd0,
        HOST_TO_DEVICE = 2'd1,
        DEVICE_TO_HOST = 2'd2
    } proxy_state_e;

    typedef enum logic [1:0] {
        LOW  = 2'd0,
        FULL = 2'd1,
        HIGH = 2'd2
    } usb_speed_e;

    // Direction bit of a log record
    localparam logic DIR_HOST_TO_DEVICE = 1'b0;
    localparam logic DIR_DEVICE_TO_HOST = 1'b1;

    // PHY event codes
    localparam logic [7:0] EVT_FULL_SPEED = 8'h01;
    localparam logic [7:0] EVT_HIGH_SPEED = 8'h02;
    localparam logic [7:0] EVT_LOW_SPEED  = 8'h03;

    // buffer_flags layout
    localparam int FLAG_DIR     = 0;
    localparam int FLAG_PID_LSB = 1;

    // status_register layout
    localparam int STAT_CONNECTED = 0;
    localparam int STAT_ERROR     = 1;
    localparam int STAT_ENABLE    = 2;
    localparam int STAT_SPEED_LSB = 6;

endpackage

// ==== hw/usb_proto_pkg.sv ====
// USB protocol definitions
// PID codes and the two readings of the 16-bit token word

package usb_proto_pkg;

    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SETUP = 4'b1101,
        PID_SOF   = 4'b0101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_DATA2 = 4'b0111,
        PID_MDATA = 4'b1111,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110,
        PID_NYET  = 4'b0110
    } usb_pid_e;

    // OUT, IN and SETUP tokens
    typedef struct packed {
        logic [4:0] crc5;
        logic [3:0] endp;
        logic [6:0] addr;
    } token_view_t;

    // Start of frame
    typedef struct packed {
        logic [4:0]  crc5;
        logic [10:0] frame;
    } sof_view_t;

    // Bytes 1 and 2 of a token packet, byte 1 in the low half
    typedef union packed {
        token_view_t token;
        sof_view_t   sof;
    } token_word_u;

endpackage

// ==== hw/usb_monitor_cfg.svh ====
// USB proxy monitor configuration
// Counter, timestamp and packet limits shared by the RTL and the testbench

`ifndef USB_MONITOR_CFG_SVH
`define USB_MONITOR_CFG_SVH

// Capture timestamp width
`define USB_TS_WIDTH 64

// Per-side packet counters
`define USB_CNT_WIDTH 32

// CRC error counter, saturating
`define USB_ERR_WIDTH 16

// Host byte counter in the decoder, saturates at all ones
`define USB_BCNT_WIDTH 3

// PID byte plus two token bytes
`define USB_TOKEN_LEN 3

`endif
